/* csr_unit.f */
rtl/csr_pkg.sv
rtl/csr_access.sv
rtl/csr_trap_regs.sv
rtl/csr_counters.sv
rtl/csr_unit.sv
tb/tb_csr_unit.sv

/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_csr_unit -Mdir obj_dir -f csr_unit.f
	./obj_dir/Vtb_csr_unit | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* tb/tb_csr_unit.sv */
// Table-driven testbench for the CSR unit. Each row issues one CSR instruction,
// optionally after a trap, interrupt or retire event, and checks the returned rd.

module tb_csr_unit
    import csr_pkg::*;
();

    localparam logic [31:0] HART     = 32'h0000_0005;
    // RV32 (MXL = 1), I and M extension bits
    localparam csr_data_t   MISA_EXP = (32'd1 << 30) | (32'd1 << 12) | (32'd1 << 8);

    typedef enum {A_NONE, A_RETIRE, A_TVEC, A_EXC, A_MRET, A_EXT, A_TAKE, A_BOTH} action_t;
    typedef enum {K_EQ, K_NONE, K_INC, K_WIN, K_MIN} kind_t;

    logic               clk, rst, new_request, oldest, ack, ready, done;
    csr_op_t            op;
    csr_addr_t          addr;
    csr_data_t          data, rd, exception_pc, trap_vector, epc;
    logic [3:0]         id, rd_id;
    logic               exception_valid, interrupt_take, mret, interrupt_pending, processing;
    logic [ECODE_W-1:0] exception_code;
    logic               m_software, m_timer, m_external;
    logic [1:0]         retire_count;

    string     names[$];
    action_t   acts[$];
    csr_op_t   ops[$];
    csr_addr_t addrs[$];
    csr_data_t datas[$];
    csr_data_t exps[$];
    kind_t     kinds[$];

    integer    seed   = 32'h83dd_ba7b;
    int        cycles = 0;
    int        limit  = 0;
    csr_data_t last_rd;
    csr_data_t last_data;

    csr_unit #(.HART_ID(HART), .RESET_MTVEC(32'h0000_0100), .COUNTER_W(64)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ends the run if the table stalls
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: the test table did not finish within %0d cycles", limit);
            $display(">>> FAIL");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "Flag mismatch");
        end
    endtask

    task automatic check_id(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "Id mismatch");
        end
    endtask

    task automatic check_range(input string name, input csr_data_t lo, input csr_data_t hi,
                               input csr_data_t act);
        if ((act > lo && act <= hi) !== 1'b1) begin
            $display("Error %s: expected in (%h, %h], actual %h", name, lo, hi, act);
            $display(">>> FAIL");
            $fatal(1, "Counter out of range");
        end
    endtask

    ////////////////////////////////////////
    // Test table
    task automatic add_test(input string name, input action_t act, input csr_op_t o,
                            input csr_addr_t a, input csr_data_t d, input csr_data_t e,
                            input kind_t k);
        names.push_back(name);
        acts.push_back(act);
        ops.push_back(o);
        addrs.push_back(a);
        datas.push_back(d);
        exps.push_back(e);
        kinds.push_back(k);
    endtask

    task automatic build_table();
        add_test("read misa", A_NONE, CSR_RS, MISA, 0, MISA_EXP, K_EQ);
        add_test("read mhartid", A_NONE, CSR_RS, MHARTID, 0, HART, K_EQ);
        add_test("write misa", A_NONE, CSR_RW, MISA, 0, MISA_EXP, K_EQ);
        add_test("misa unchanged", A_NONE, CSR_RS, MISA, 0, MISA_EXP, K_EQ);
        add_test("unknown addr", A_NONE, CSR_RW, 12'h7C0, 32'hFFFF_FFFF, 0, K_EQ);
        add_test("mscratch init", A_NONE, CSR_RW, MSCRATCH, 32'hA5A5_0F0F, 0, K_NONE);
        add_test("mscratch read", A_NONE, CSR_RS, MSCRATCH, 0, 32'hA5A5_0F0F, K_EQ);
        add_test("mscratch set", A_NONE, CSR_RS, MSCRATCH, 32'h0000_F0F0, 32'hA5A5_0F0F, K_EQ);
        add_test("mscratch clear", A_NONE, CSR_RC, MSCRATCH, 32'hA500_0000, 32'hA5A5_FFFF, K_EQ);
        add_test("mscratch swap", A_NONE, CSR_RW, MSCRATCH, 32'h5A5A_1234, 32'h00A5_FFFF, K_EQ);
        add_test("mcycle first", A_NONE, CSR_RS, MCYCLE, 0, 0, K_NONE);
        add_test("mcycle second", A_NONE, CSR_RS, MCYCLE, 0, 30, K_INC);
        add_test("cycle alias", A_NONE, CSR_RS, CYCLE, 0, 30, K_INC);
        add_test("mcycle write", A_NONE, CSR_RW, MCYCLE, 32'h1000_0000, 0, K_NONE);
        add_test("mcycle after write", A_NONE, CSR_RS, MCYCLE, 0, 24, K_WIN);
        add_test("minstret base", A_NONE, CSR_RS, MINSTRET, 0, 0, K_NONE);
        add_test("minstret retire", A_RETIRE, CSR_RS, MINSTRET, 0, 10, K_MIN);
        add_test("mstatus set mie", A_NONE, CSR_RS, MSTATUS, 32'h8, 32'h0000_1800, K_EQ);
        add_test("mtvec write", A_NONE, CSR_RW, MTVEC, 32'h0000_2003, 32'h0000_0100, K_EQ);
        add_test("mtvec read", A_TVEC, CSR_RS, MTVEC, 0, 32'h0000_2000, K_EQ);
        add_test("mepc after exc", A_EXC, CSR_RS, MEPC, 0, 32'h0000_1234, K_EQ);
        add_test("mcause exc", A_NONE, CSR_RS, MCAUSE, 0, 32'd11, K_EQ);
        add_test("mstatus trapped", A_NONE, CSR_RS, MSTATUS, 0, 32'h0000_1880, K_EQ);
        add_test("mstatus mret", A_MRET, CSR_RS, MSTATUS, 0, 32'h0000_1888, K_EQ);
        add_test("mie enable", A_NONE, CSR_RW, MIE, 32'h0000_0880, 0, K_EQ);
        add_test("mip external", A_EXT, CSR_RS, MIP, 0, 32'h0000_0800, K_EQ);
        add_test("mcause ext int", A_TAKE, CSR_RS, MCAUSE, 0, 32'h8000_000B, K_EQ);
        add_test("mstatus mret 2", A_MRET, CSR_RS, MSTATUS, 0, 32'h0000_1888, K_EQ);
        add_test("mcause both int", A_BOTH, CSR_RS, MCAUSE, 0, 32'h8000_000B, K_EQ);
        add_test("mip both", A_NONE, CSR_RS, MIP, 0, 32'h0000_0880, K_EQ);
    endtask

    ////////////////////////////////////////
    // Events between instructions
    task automatic apply_action(input action_t act);
        case (act)
            A_RETIRE: begin
                @(posedge clk);
                retire_count <= 2'd2;
                repeat (5) @(posedge clk);
                retire_count <= 2'd0;
            end
            A_TVEC: begin
                @(negedge clk);
                check_data("trap_vector", 32'h0000_2000, trap_vector);
            end
            A_EXC: begin
                @(posedge clk);
                exception_valid <= 1'b1;
                exception_code  <= ECALL_M;
                exception_pc    <= 32'h0000_1237;
                @(posedge clk);
                exception_valid <= 1'b0;
                @(negedge clk);
                check_data("epc", 32'h0000_1234, epc);
            end
            A_MRET: begin
                @(posedge clk);
                mret <= 1'b1;
                @(posedge clk);
                mret <= 1'b0;
            end
            A_EXT: begin
                @(posedge clk);
                m_external <= 1'b1;
                // mip follows the input one cycle late
                repeat (2) @(posedge clk);
                @(negedge clk);
                check_flag("pending on external", 1'b1, interrupt_pending);
            end
            A_TAKE, A_BOTH: begin
                if (act == A_BOTH) begin
                    @(posedge clk);
                    m_timer <= 1'b1;
                    repeat (2) @(posedge clk);
                end
                @(posedge clk);
                interrupt_take <= 1'b1;
                @(posedge clk);
                interrupt_take <= 1'b0;
                @(negedge clk);
                check_flag("pending after take", 1'b0, interrupt_pending);
            end
            default: ;
        endcase
    endtask

    task automatic check_result(input int i, input csr_data_t value);
        case (kinds[i])
            K_EQ:    check_data(names[i], exps[i], value);
            K_INC:   check_range(names[i], last_rd, last_rd + exps[i], value);
            K_WIN:   check_range(names[i], last_data, last_data + exps[i], value);
            K_MIN:   check_range(names[i], last_rd + exps[i] - 1, 32'hFFFF_FFFF, value);
            default: ;
        endcase
        last_rd   = value;
        last_data = datas[i];
    endtask

    // One CSR instruction through issue, commit and writeback
    task automatic run_entry(input int i);
        int        delay;
        csr_data_t held;
        apply_action(acts[i]);
        @(posedge clk);
        new_request <= 1'b1;
        op          <= ops[i];
        addr        <= addrs[i];
        data        <= datas[i];
        id          <= 4'(i);
        @(negedge clk);
        check_flag({names[i], " processing"}, 1'b1, processing);
        @(posedge clk);
        new_request <= 1'b0;
        @(negedge clk);
        check_flag({names[i], " ready"}, 1'b0, ready);
        check_flag({names[i], " busy"}, 1'b1, processing);
        check_flag({names[i], " early done"}, 1'b0, done);
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            @(posedge clk);
            @(negedge clk);
            check_flag({names[i], " early done"}, 1'b0, done);
        end
        @(posedge clk);
        oldest <= 1'b1;
        @(negedge clk);
        while (!done) @(negedge clk);
        held = rd;
        check_id({names[i], " rd_id"}, 4'(i), rd_id);
        @(posedge clk);
        oldest <= 1'b0;
        // Back-pressure on every fourth instruction
        if (i % 4 == 1) begin
            repeat (3) begin
                @(negedge clk);
                check_flag({names[i], " done held"}, 1'b1, done);
                check_data({names[i], " rd held"}, held, rd);
            end
            @(posedge clk);
        end
        ack <= 1'b1;
        @(posedge clk);
        ack <= 1'b0;
        @(negedge clk);
        check_flag({names[i], " ready after ack"}, 1'b1, ready);
        check_flag({names[i], " idle after ack"}, 1'b0, processing);
        check_result(i, held);
    endtask

    initial begin
        rst             = 1'b1;
        new_request     = 1'b0;
        op              = CSR_RW;
        addr            = '0;
        data            = '0;
        id              = '0;
        oldest          = 1'b0;
        ack             = 1'b0;
        exception_valid = 1'b0;
        exception_code  = '0;
        exception_pc    = '0;
        interrupt_take  = 1'b0;
        mret            = 1'b0;
        m_software      = 1'b0;
        m_timer         = 1'b0;
        m_external      = 1'b0;
        retire_count    = 2'd0;
        build_table();
        limit = acts.size() * 10 + 100;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < acts.size(); i++)
            run_entry(i);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* rtl/csr_unit.sv */
// Top level of the machine-mode CSR unit. The access sequencer drives both
// register banks and merges their read results; parameters are passed down.

module csr_unit
    import csr_pkg::*;
#(
    parameter logic [31:0] HART_ID     = 32'd0,
    parameter logic [31:0] RESET_MTVEC = 32'h0000_0100,
    parameter int          COUNTER_W   = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               new_request,
    input  csr_op_t            op,
    input  csr_addr_t          addr,
    input  csr_data_t          data,
    input  logic [3:0]         id,
    output logic               ready,
    input  logic               oldest,
    output logic               done,
    output csr_data_t          rd,
    output logic [3:0]         rd_id,
    input  logic               ack,
    input  logic               exception_valid,
    input  logic [ECODE_W-1:0] exception_code,
    input  csr_data_t          exception_pc,
    input  logic               interrupt_take,
    input  logic               mret,
    input  logic               m_software,
    input  logic               m_timer,
    input  logic               m_external,
    input  logic [1:0]         retire_count,
    output logic               interrupt_pending,
    output csr_data_t          trap_vector,
    output csr_data_t          epc,
    output logic               processing
);

    csr_addr_t csr_addr;
    logic      write_en;
    csr_data_t write_data;
    csr_data_t trap_read_data;
    csr_data_t counter_read_data;

    // Busy or accepting a new instruction this cycle
    assign processing = !ready || new_request;

    csr_access u_access (
        .clk, .rst, .new_request, .op, .addr, .data, .id, .ready, .oldest,
        .done, .rd, .rd_id, .ack, .trap_read_data, .counter_read_data,
        .csr_addr, .write_en, .write_data
    );

    csr_trap_regs #(.HART_ID(HART_ID), .RESET_MTVEC(RESET_MTVEC)) u_trap_regs (
        .clk, .rst, .csr_addr, .write_en, .write_data, .read_data(trap_read_data),
        .exception_valid, .exception_code, .exception_pc, .interrupt_take, .mret,
        .m_software, .m_timer, .m_external, .interrupt_pending, .trap_vector, .epc
    );

    csr_counters #(.COUNTER_W(COUNTER_W)) u_counters (
        .clk, .rst, .csr_addr, .write_en, .write_data, .retire_count,
        .read_data(counter_read_data)
    );

endmodule

/* rtl/csr_counters.sv */
// Cycle and retired-instruction counter bank with the user aliases.
// A CSR write to either half replaces the increment for that cycle.

module csr_counters
    import csr_pkg::*;
#(
    parameter int COUNTER_W = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  csr_addr_t  csr_addr,
    input  logic       write_en,
    input  csr_data_t  write_data,
    input  logic [1:0] retire_count,
    output csr_data_t  read_data
);

    logic [COUNTER_W-1:0] mcycle;
    logic [COUNTER_W-1:0] minstret;
    logic                 cycle_wr;
    logic                 instret_wr;

    // Loads the written half of a counter, other bits unchanged
    function automatic logic [COUNTER_W-1:0] load_half(
        input logic [COUNTER_W-1:0] cur,
        input logic                 wr_lo,
        input logic                 wr_hi,
        input csr_data_t            wd
    );
        logic [COUNTER_W-1:0] nxt;
        nxt = cur;
        if (wr_lo)
            nxt[XLEN-1:0] = wd;
        if (wr_hi)
            nxt[COUNTER_W-1:XLEN] = wd[COUNTER_W-XLEN-1:0];
        return nxt;
    endfunction

    assign cycle_wr   = write_en && (csr_addr == MCYCLE || csr_addr == MCYCLEH);
    assign instret_wr = write_en && (csr_addr == MINSTRET || csr_addr == MINSTRETH);

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= load_half(mcycle, write_en && csr_addr == MCYCLE,
                                  write_en && csr_addr == MCYCLEH, write_data)
                        + COUNTER_W'(!cycle_wr);
            minstret <= load_half(minstret, write_en && csr_addr == MINSTRET,
                                  write_en && csr_addr == MINSTRETH, write_data)
                        + COUNTER_W'(instret_wr ? 2'd0 : retire_count);
        end
    end

    always_comb begin
        case (csr_addr)
            MCYCLE, CYCLE:       read_data = mcycle[XLEN-1:0];
            MINSTRET, INSTRET:   read_data = minstret[XLEN-1:0];
            MCYCLEH, CYCLEH:     read_data = XLEN'(mcycle[COUNTER_W-1:XLEN]);
            MINSTRETH, INSTRETH: read_data = XLEN'(minstret[COUNTER_W-1:XLEN]);
            default:             read_data = '0;
        endcase
    end

endmodule

/* rtl/csr_trap_regs.sv */
// Machine trap register bank. Holds mstatus, mtvec, mepc, mcause, mscratch, mie
// and mip, answers misa and mhartid, and handles trap entry and mret.
// Reads return zero for addresses outside this bank.

module csr_trap_regs
    import csr_pkg::*;
#(
    parameter logic [31:0] HART_ID     = 32'd0,
    parameter logic [31:0] RESET_MTVEC = 32'd0
) (
    input  logic               clk,
    input  logic               rst,

    input  csr_addr_t          csr_addr,
    input  logic               write_en,
    input  csr_data_t          write_data,
    output csr_data_t          read_data,

    input  logic               exception_valid,
    input  logic [ECODE_W-1:0] exception_code,
    input  csr_data_t          exception_pc,
    input  logic               interrupt_take,
    input  logic               mret,

    input  logic               m_software,
    input  logic               m_timer,
    input  logic               m_external,

    output logic               interrupt_pending,
    output csr_data_t          trap_vector,
    output csr_data_t          epc
);

    logic               status_mie;
    logic               status_mpie;
    logic [XLEN-1:2]    mtvec_q;
    logic [XLEN-1:2]    mepc_q;
    logic               cause_int;
    logic [ECODE_W-1:0] cause_code;
    csr_data_t          mscratch_q;
    logic               ie_msi, ie_mti, ie_mei;
    logic               ip_msi, ip_mti, ip_mei;

    logic               trap_entry;
    logic [ECODE_W-1:0] interrupt_code;
    csr_data_t          mstatus_word;
    csr_data_t          mie_word;
    csr_data_t          mip_word;

    assign trap_entry = exception_valid || interrupt_take;

    ////////////////////////////////////////
    // mstatus
    // Machine mode only, so MPP stays at 3
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
        end else if (write_en && csr_addr == MSTATUS) begin
            status_mie  <= write_data[MSTATUS_MIE];
            status_mpie <= write_data[MSTATUS_MPIE];
        end else if (trap_entry) begin
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
        end else if (mret) begin
            status_mie  <= status_mpie;
            status_mpie <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            mtvec_q <= RESET_MTVEC[XLEN-1:2];
        else if (write_en && csr_addr == MTVEC)
            mtvec_q <= write_data[XLEN-1:2];
    end

    // Trap PC wins over a software write in the same cycle
    always_ff @(posedge clk) begin
        if (trap_entry)
            mepc_q <= exception_pc[XLEN-1:2];
        else if (write_en && csr_addr == MEPC)
            mepc_q <= write_data[XLEN-1:2];
    end

    always_ff @(posedge clk) begin
        if (write_en && csr_addr == MSCRATCH)
            mscratch_q <= write_data;
    end

    ////////////////////////////////////////
    // Interrupts
    always_ff @(posedge clk) begin
        if (rst) begin
            ie_msi <= 1'b0;
            ie_mti <= 1'b0;
            ie_mei <= 1'b0;
        end else if (write_en && csr_addr == MIE) begin
            ie_msi <= write_data[MSI];
            ie_mti <= write_data[MTI];
            ie_mei <= write_data[MEI];
        end
    end

    // Timer and external pending bits just track their sources
    always_ff @(posedge clk) begin
        if (rst) begin
            ip_msi <= 1'b0;
            ip_mti <= 1'b0;
            ip_mei <= 1'b0;
        end else begin
            if (write_en && csr_addr == MIP)
                ip_msi <= write_data[MSI] | m_software;
            else if (m_software)
                ip_msi <= 1'b1;
            ip_mti <= m_timer;
            ip_mei <= m_external;
        end
    end

    // Priority external, software, timer
    always_comb begin
        if (ip_mei && ie_mei)
            interrupt_code = M_EXTERNAL_INT;
        else if (ip_msi && ie_msi)
            interrupt_code = M_SOFTWARE_INT;
        else
            interrupt_code = M_TIMER_INT;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cause_int  <= 1'b0;
            cause_code <= '0;
        end else if (interrupt_take) begin
            cause_int  <= 1'b1;
            cause_code <= interrupt_code;
        end else if (exception_valid) begin
            cause_int  <= 1'b0;
            cause_code <= exception_code;
        end else if (write_en && csr_addr == MCAUSE) begin
            cause_int  <= write_data[XLEN-1];
            cause_code <= write_data[ECODE_W-1:0];
        end
    end

    assign interrupt_pending = |(mip_word & mie_word) && status_mie;

    ////////////////////////////////////////
    // Read mux
    always_comb begin
        mstatus_word                           = '0;
        mstatus_word[MSTATUS_MIE]              = status_mie;
        mstatus_word[MSTATUS_MPIE]             = status_mpie;
        mstatus_word[MSTATUS_MPP+:2]           = 2'b11;
        mie_word                               = '0;
        mie_word[MSI]                          = ie_msi;
        mie_word[MTI]                          = ie_mti;
        mie_word[MEI]                          = ie_mei;
        mip_word                               = '0;
        mip_word[MSI]                          = ip_msi;
        mip_word[MTI]                          = ip_mti;
        mip_word[MEI]                          = ip_mei;
    end

    assign trap_vector = {mtvec_q, 2'b00};
    assign epc         = {mepc_q, 2'b00};

    always_comb begin
        case (csr_addr)
            MISA:     read_data = MISA_VALUE;
            MHARTID:  read_data = HART_ID;
            MSTATUS:  read_data = mstatus_word;
            MIE:      read_data = mie_word;
            MTVEC:    read_data = trap_vector;
            MSCRATCH: read_data = mscratch_q;
            MEPC:     read_data = epc;
            MCAUSE:   read_data = {cause_int, {(XLEN-1-ECODE_W){1'b0}}, cause_code};
            MIP:      read_data = mip_word;
            default:  read_data = '0;
        endcase
    end

    // The pipeline takes an interrupt only when no exception is pending
    assert property (@(posedge clk) disable iff (rst) !(interrupt_take && exception_valid));

endmodule

/* rtl/csr_access.sv */
// Access sequencer of the CSR unit. Registers one CSR instruction, waits until it
// is the oldest, captures the merged read value and issues the write one cycle later.
// The result is held on done/rd/rd_id until the pipeline acknowledges it.

module csr_access
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Issue
    input  logic       new_request,
    input  csr_op_t    op,
    input  csr_addr_t  addr,
    input  csr_data_t  data,
    input  logic [3:0] id,
    output logic       ready,

    input  logic       oldest,

    // Writeback
    output logic       done,
    output csr_data_t  rd,
    output logic [3:0] rd_id,
    input  logic       ack,

    // Register banks
    input  csr_data_t  trap_read_data,
    input  csr_data_t  counter_read_data,
    output csr_addr_t  csr_addr,
    output logic       write_en,
    output csr_data_t  write_data
);

    seq_state_t state;

    csr_op_t    op_q;
    csr_addr_t  addr_q;
    csr_data_t  data_q;
    logic [3:0] id_q;

    logic       commit;
    logic       writable;
    csr_data_t  read_merged;
    csr_data_t  rmw_result;

    ////////////////////////////////////////
    // Sequencer
    assign ready  = (state == SEQ_IDLE);
    assign done   = (state == SEQ_DONE);
    assign commit = (state == SEQ_WAIT) && oldest;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
        end else begin
            case (state)
                SEQ_IDLE: if (new_request) state <= SEQ_WAIT;
                SEQ_WAIT: if (oldest) state <= SEQ_DONE;
                SEQ_DONE: if (ack) state <= SEQ_IDLE;
                default:  state <= SEQ_IDLE;
            endcase
        end
    end

    // Request stays put until the next issue, so the write sees the same address
    always_ff @(posedge clk) begin
        if (new_request && ready) begin
            op_q   <= op;
            addr_q <= addr;
            data_q <= data;
            id_q   <= id;
        end
    end

    assign csr_addr = addr_q;
    assign rd_id    = id_q;

    ////////////////////////////////////////
    // Read-modify-write
    // Banks return zero for addresses they do not own
    assign read_merged = trap_read_data | counter_read_data;

    assign writable = (addr_q[11:10] != ADDR_RO_BITS) && (addr_q[9:8] == ADDR_PRIV_BITS);

    always_comb begin
        case (op_q)
            CSR_RS:  rmw_result = read_merged | data_q;
            CSR_RC:  rmw_result = read_merged & ~data_q;
            default: rmw_result = data_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            rd         <= read_merged;
            write_data <= rmw_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            write_en <= 1'b0;
        else
            write_en <= commit && writable;
    end

    // Pipeline side of the handshake
    assert property (@(posedge clk) disable iff (rst) new_request |-> state == SEQ_IDLE);
    assert property (@(posedge clk) disable iff (rst) ack |-> done);

endmodule

/* rtl/csr_pkg.sv */
// Shared widths, CSR addresses, opcodes and bit positions for the CSR unit.
// Every RTL file of the unit imports this package in its module header.

package csr_pkg;

    localparam int XLEN    = 32;
    localparam int ECODE_W = 5;

    typedef logic [11:0]     csr_addr_t;
    typedef logic [XLEN-1:0] csr_data_t;

    // Matches funct3 of the CSR instructions
    typedef enum logic [2:0] {
        CSR_RW = 3'd1,
        CSR_RS = 3'd2,
        CSR_RC = 3'd3
    } csr_op_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT,
        SEQ_DONE
    } seq_state_t;

    ////////////////////////////////////////
    // CSR addresses
    localparam csr_addr_t MSTATUS   = 12'h300;
    localparam csr_addr_t MISA      = 12'h301;
    localparam csr_addr_t MIE       = 12'h304;
    localparam csr_addr_t MTVEC     = 12'h305;
    localparam csr_addr_t MSCRATCH  = 12'h340;
    localparam csr_addr_t MEPC      = 12'h341;
    localparam csr_addr_t MCAUSE    = 12'h342;
    localparam csr_addr_t MIP       = 12'h344;
    localparam csr_addr_t MHARTID   = 12'hF14;
    localparam csr_addr_t MCYCLE    = 12'hB00;
    localparam csr_addr_t MINSTRET  = 12'hB02;
    localparam csr_addr_t MCYCLEH   = 12'hB80;
    localparam csr_addr_t MINSTRETH = 12'hB82;
    localparam csr_addr_t CYCLE     = 12'hC00;
    localparam csr_addr_t INSTRET   = 12'hC02;
    localparam csr_addr_t CYCLEH    = 12'hC80;
    localparam csr_addr_t INSTRETH  = 12'hC82;

    // Field values of addr[11:10] (read-only) and addr[9:8] (machine level)
    localparam logic [1:0] ADDR_RO_BITS   = 2'd3;
    localparam logic [1:0] ADDR_PRIV_BITS = 2'd3;

    ////////////////////////////////////////
    // Cause codes
    localparam logic [ECODE_W-1:0] M_SOFTWARE_INT = 5'd3;
    localparam logic [ECODE_W-1:0] M_TIMER_INT    = 5'd7;
    localparam logic [ECODE_W-1:0] M_EXTERNAL_INT = 5'd11;
    localparam logic [ECODE_W-1:0] ILLEGAL_INST   = 5'd2;
    localparam logic [ECODE_W-1:0] BREAK          = 5'd3;
    localparam logic [ECODE_W-1:0] ECALL_M        = 5'd11;

    // mstatus bits, MPP is the low bit of a two-bit field
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11;

    // Interrupt enable and pending bits in mie and mip
    localparam int MSI = 3;
    localparam int MTI = 7;
    localparam int MEI = 11;

    // RV32I with M extension, MXL = 1
    localparam csr_data_t MISA_VALUE = 32'h4000_1100;

endpackage
